//--- source/riscv_em_macros.svh
`ifndef RISCV_EM_MACROS_SVH
`define RISCV_EM_MACROS_SVH

// datapath widths
`define RISCV_EM_XLEN              64
`define RISCV_EM_RADDR_W           5

// mcause encoding for the exceptions raised in the memory stage
`define RISCV_EM_CAUSE_W           4
`define RISCV_EM_CAUSE_LD_MISALIGN 4
`define RISCV_EM_CAUSE_ST_MISALIGN 6

`endif

//--- source/riscv_em_ctrl_pkg.sv
`include "riscv_em_macros.svh"

package riscv_em_ctrl_pkg;

    // execute-side alu functions
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4
    } aluop_e;

    // write-back source select
    typedef enum logic [1:0] {
        RES_ALU  = 2'd0,
        RES_LOAD = 2'd1,
        RES_PC4  = 2'd2,
        RES_IMM  = 2'd3
    } resultsrc_e;

    // bit 2 unsigned, bits 1:0 log2 of the size, as in funct3
    typedef enum logic [2:0] {
        MEXT_B  = 3'b000,
        MEXT_H  = 3'b001,
        MEXT_W  = 3'b010,
        MEXT_D  = 3'b011,
        MEXT_BU = 3'b100,
        MEXT_HU = 3'b101,
        MEXT_WU = 3'b110,
        MEXT_DU = 3'b111
    } memext_e;

    typedef struct packed {
        logic                          valid;
        logic                          regw;
        logic                          memread;
        logic                          memwrite;
        resultsrc_e                    resultsrc;
        memext_e                       memext;
        logic [`RISCV_EM_RADDR_W-1:0]  rdaddr;
    } em_ctrl_t;

endpackage

//--- source/riscv_em_data_pkg.sv
`include "riscv_em_macros.svh"

package riscv_em_data_pkg;

    // payload carried from execute into memory
    typedef struct packed {
        logic [`RISCV_EM_XLEN-1:0] result;
        logic [`RISCV_EM_XLEN-1:0] address;
        logic [`RISCV_EM_XLEN-1:0] storedata;
        logic [`RISCV_EM_XLEN-1:0] pcplus4;
        logic [`RISCV_EM_XLEN-1:0] imm;
        logic                      ld_misalign;
        logic                      st_misalign;
    } em_data_t;

    // data-memory port, one doubleword per access
    typedef struct packed {
        logic [`RISCV_EM_XLEN-1:0]   addr;
        logic [`RISCV_EM_XLEN-1:0]   wdata;
        logic                        we;
        logic [`RISCV_EM_XLEN/8-1:0] strb;
    } dmem_req_t;

endpackage

//--- source/riscv_em_ppreg.sv
`timescale 1ns/1ps

module riscv_em_ppreg #(
    parameter type T = logic
) (
    input  logic i_riscv_em_clk,
    input  logic i_riscv_em_rst,
    input  logic i_riscv_em_stall,
    input  logic i_riscv_em_flush,
    input  T     i_riscv_em_d,
    output T     o_riscv_em_q
);

    always_ff @(posedge i_riscv_em_clk or posedge i_riscv_em_rst)
    begin
        if (i_riscv_em_rst)
        begin
            o_riscv_em_q <= '0;
        end
        else if (i_riscv_em_flush) // flush beats stall
        begin
            o_riscv_em_q <= '0;
        end
        else if (!i_riscv_em_stall)
        begin
            o_riscv_em_q <= i_riscv_em_d;
        end
    end

    // a flushed slot reaches the memory stage as a bubble
    property p_flush_clears;
        @(posedge i_riscv_em_clk) disable iff (i_riscv_em_rst)
        i_riscv_em_flush |=> (o_riscv_em_q == '0);
    endproperty

    a_flush_clears: assert property (p_flush_clears)
    else $error("ppreg output not cleared after flush");

endmodule

//--- source/riscv_em_exec_side.sv
`timescale 1ns/1ps
`include "riscv_em_macros.svh"

module riscv_em_exec_side
    import riscv_em_ctrl_pkg::*, riscv_em_data_pkg::*;
(
    input  logic                          i_riscv_em_valid,
    input  logic [`RISCV_EM_XLEN-1:0]     i_riscv_em_opa,
    input  logic [`RISCV_EM_XLEN-1:0]     i_riscv_em_opb,
    input  aluop_e                        i_riscv_em_aluop,
    input  logic                          i_riscv_em_regw,
    input  logic                          i_riscv_em_memread,
    input  logic                          i_riscv_em_memwrite,
    input  resultsrc_e                    i_riscv_em_resultsrc,
    input  memext_e                       i_riscv_em_memext,
    input  logic [`RISCV_EM_RADDR_W-1:0]  i_riscv_em_rdaddr,
    input  logic [`RISCV_EM_XLEN-1:0]     i_riscv_em_imm,
    input  logic [`RISCV_EM_XLEN-1:0]     i_riscv_em_pc,
    input  logic [`RISCV_EM_XLEN-1:0]     i_riscv_em_storedata,
    output em_ctrl_t                      o_riscv_em_ctrl,
    output em_data_t                      o_riscv_em_data
);

    logic [`RISCV_EM_XLEN-1:0] alu_result;
    logic [`RISCV_EM_XLEN-1:0] address;
    logic [`RISCV_EM_XLEN-1:0] pcplus4;
    logic [2:0]                ext_bits;
    logic                      misaligned;

    assign address  = i_riscv_em_opa + i_riscv_em_imm;
    assign pcplus4  = i_riscv_em_pc + `RISCV_EM_XLEN'd4;
    assign ext_bits = i_riscv_em_memext;

    always_comb
    begin
        case (i_riscv_em_aluop)
            ALU_ADD: alu_result = i_riscv_em_opa + i_riscv_em_opb;
            ALU_SUB: alu_result = i_riscv_em_opa - i_riscv_em_opb;
            ALU_AND: alu_result = i_riscv_em_opa & i_riscv_em_opb;
            ALU_OR:  alu_result = i_riscv_em_opa | i_riscv_em_opb;
            ALU_XOR: alu_result = i_riscv_em_opa ^ i_riscv_em_opb;
            default: alu_result = '0;
        endcase
    end

    // natural alignment per access size
    always_comb
    begin
        case (ext_bits[1:0])
            2'd0:    misaligned = 1'b0;
            2'd1:    misaligned = address[0];
            2'd2:    misaligned = |address[1:0];
            default: misaligned = |address[2:0];
        endcase
    end

    always_comb
    begin
        o_riscv_em_ctrl.valid     = i_riscv_em_valid;
        o_riscv_em_ctrl.regw      = i_riscv_em_regw;
        o_riscv_em_ctrl.memread   = i_riscv_em_memread;
        o_riscv_em_ctrl.memwrite  = i_riscv_em_memwrite;
        o_riscv_em_ctrl.resultsrc = i_riscv_em_resultsrc;
        o_riscv_em_ctrl.memext    = i_riscv_em_memext;
        o_riscv_em_ctrl.rdaddr    = i_riscv_em_rdaddr;
    end

    always_comb
    begin
        o_riscv_em_data.result      = alu_result;
        o_riscv_em_data.address     = address;
        o_riscv_em_data.storedata   = i_riscv_em_storedata;
        o_riscv_em_data.pcplus4     = pcplus4;
        o_riscv_em_data.imm         = i_riscv_em_imm;
        o_riscv_em_data.ld_misalign = i_riscv_em_valid & i_riscv_em_memread & misaligned;
        o_riscv_em_data.st_misalign = i_riscv_em_valid & i_riscv_em_memwrite & misaligned;
    end

endmodule

//--- source/riscv_em_mem_stage.sv
`timescale 1ns/1ps
`include "riscv_em_macros.svh"

module riscv_em_mem_stage
    import riscv_em_ctrl_pkg::*, riscv_em_data_pkg::*;
(
    input  em_ctrl_t                   i_riscv_em_ctrl,
    input  em_data_t                   i_riscv_em_data,
    input  logic [`RISCV_EM_XLEN-1:0]  i_riscv_em_dmem_rdata,
    output dmem_req_t                  o_riscv_em_dmem_req,
    output logic [`RISCV_EM_XLEN-1:0]  o_riscv_em_load_value
);

    logic [2:0]                  offset;
    logic [5:0]                  bit_shift;
    logic [2:0]                  ext_bits;
    logic [`RISCV_EM_XLEN/8-1:0] strb_base;
    logic [`RISCV_EM_XLEN/8-1:0] strb_lanes;
    logic [`RISCV_EM_XLEN-1:0]   lane_data;
    logic [`RISCV_EM_XLEN-1:0]   rdata_sh;
    logic [`RISCV_EM_XLEN-1:0]   load_ext;
    logic                        store_ok;

    assign offset    = i_riscv_em_data.address[2:0];
    assign bit_shift = {offset, 3'b000};
    assign ext_bits  = i_riscv_em_ctrl.memext;

    // misaligned stores never reach memory
    assign store_ok = i_riscv_em_ctrl.valid & i_riscv_em_ctrl.memwrite &
                      ~i_riscv_em_data.st_misalign;

    always_comb
    begin
        case (ext_bits[1:0])
            2'd0:    strb_base = 8'h01;
            2'd1:    strb_base = 8'h03;
            2'd2:    strb_base = 8'h0f;
            default: strb_base = 8'hff;
        endcase
    end

    assign strb_lanes = strb_base << offset;
    assign lane_data  = i_riscv_em_data.storedata << bit_shift;

    always_comb
    begin
        o_riscv_em_dmem_req.addr  = {i_riscv_em_data.address[`RISCV_EM_XLEN-1:3], 3'b000};
        o_riscv_em_dmem_req.wdata = lane_data;
        o_riscv_em_dmem_req.we    = store_ok;
        o_riscv_em_dmem_req.strb  = store_ok ? strb_lanes : '0;
    end

    // addressed byte moved down to lane 0
    assign rdata_sh = i_riscv_em_dmem_rdata >> bit_shift;

    always_comb
    begin
        case (i_riscv_em_ctrl.memext)
            MEXT_B:  load_ext = {{56{rdata_sh[7]}}, rdata_sh[7:0]};
            MEXT_H:  load_ext = {{48{rdata_sh[15]}}, rdata_sh[15:0]};
            MEXT_W:  load_ext = {{32{rdata_sh[31]}}, rdata_sh[31:0]};
            MEXT_BU: load_ext = {56'd0, rdata_sh[7:0]};
            MEXT_HU: load_ext = {48'd0, rdata_sh[15:0]};
            MEXT_WU: load_ext = {32'd0, rdata_sh[31:0]};
            default: load_ext = rdata_sh; // doubleword either way
        endcase
    end

    assign o_riscv_em_load_value = i_riscv_em_ctrl.memread ? load_ext : '0;

    // flag comes from the execute side, gate lives here
    always_comb
    begin
        a_no_misaligned_write: assert final (!(o_riscv_em_dmem_req.we &&
                                               i_riscv_em_data.st_misalign))
        else $error("write enable high on a misaligned store");
    end

endmodule

//--- source/riscv_em_wb_select.sv
`timescale 1ns/1ps
`include "riscv_em_macros.svh"

module riscv_em_wb_select
    import riscv_em_ctrl_pkg::*, riscv_em_data_pkg::*;
(
    input  em_ctrl_t                       i_riscv_em_ctrl,
    input  em_data_t                       i_riscv_em_data,
    input  logic [`RISCV_EM_XLEN-1:0]      i_riscv_em_load_value,
    output logic [`RISCV_EM_XLEN-1:0]      o_riscv_em_rd_data,
    output logic [`RISCV_EM_RADDR_W-1:0]   o_riscv_em_rd_addr,
    output logic                           o_riscv_em_regw,
    output logic                           o_riscv_em_trap,
    output logic [`RISCV_EM_CAUSE_W-1:0]   o_riscv_em_trap_cause
);

    logic ld_trap;
    logic st_trap;

    assign ld_trap = i_riscv_em_ctrl.valid & i_riscv_em_data.ld_misalign;
    assign st_trap = i_riscv_em_ctrl.valid & i_riscv_em_data.st_misalign;

    always_comb
    begin
        case (i_riscv_em_ctrl.resultsrc)
            RES_ALU:  o_riscv_em_rd_data = i_riscv_em_data.result;
            RES_LOAD: o_riscv_em_rd_data = i_riscv_em_load_value;
            RES_PC4:  o_riscv_em_rd_data = i_riscv_em_data.pcplus4;
            default:  o_riscv_em_rd_data = i_riscv_em_data.imm; // lui style
        endcase
    end

    assign o_riscv_em_rd_addr = i_riscv_em_ctrl.rdaddr;
    assign o_riscv_em_trap    = ld_trap | st_trap;

    // trapping instruction must not retire
    assign o_riscv_em_regw = i_riscv_em_ctrl.valid & i_riscv_em_ctrl.regw &
                             ~o_riscv_em_trap;

    always_comb
    begin
        if (ld_trap)
        begin
            o_riscv_em_trap_cause = `RISCV_EM_CAUSE_W'(`RISCV_EM_CAUSE_LD_MISALIGN);
        end
        else if (st_trap)
        begin
            o_riscv_em_trap_cause = `RISCV_EM_CAUSE_W'(`RISCV_EM_CAUSE_ST_MISALIGN);
        end
        else
        begin
            o_riscv_em_trap_cause = '0;
        end
    end

endmodule

//--- source/riscv_em_top.sv
`timescale 1ns/1ps
`include "riscv_em_macros.svh"

module riscv_em_top
    import riscv_em_ctrl_pkg::*, riscv_em_data_pkg::*;
(
    input  logic                          i_riscv_em_clk,
    input  logic                          i_riscv_em_rst,
    input  logic                          i_riscv_em_valid,
    input  logic [`RISCV_EM_XLEN-1:0]     i_riscv_em_opa,
    input  logic [`RISCV_EM_XLEN-1:0]     i_riscv_em_opb,
    input  aluop_e                        i_riscv_em_aluop,
    input  logic                          i_riscv_em_regw,
    input  logic                          i_riscv_em_memread,
    input  logic                          i_riscv_em_memwrite,
    input  resultsrc_e                    i_riscv_em_resultsrc,
    input  memext_e                       i_riscv_em_memext,
    input  logic [`RISCV_EM_RADDR_W-1:0]  i_riscv_em_rdaddr,
    input  logic [`RISCV_EM_XLEN-1:0]     i_riscv_em_imm,
    input  logic [`RISCV_EM_XLEN-1:0]     i_riscv_em_pc,
    input  logic [`RISCV_EM_XLEN-1:0]     i_riscv_em_storedata,
    input  logic                          i_riscv_em_stall,
    input  logic                          i_riscv_em_flush,
    input  logic [`RISCV_EM_XLEN-1:0]     i_riscv_em_dmem_rdata,
    output dmem_req_t                     o_riscv_em_dmem_req,
    output logic [`RISCV_EM_XLEN-1:0]     o_riscv_em_rd_data,
    output logic [`RISCV_EM_RADDR_W-1:0]  o_riscv_em_rd_addr,
    output logic                          o_riscv_em_regw,
    output logic                          o_riscv_em_trap,
    output logic [`RISCV_EM_CAUSE_W-1:0]  o_riscv_em_trap_cause
);

    em_ctrl_t                  ctrl_e;
    em_ctrl_t                  ctrl_m;
    em_data_t                  data_e;
    em_data_t                  data_m;
    logic [`RISCV_EM_XLEN-1:0] load_value;

    riscv_em_exec_side u_exec_side (
        .i_riscv_em_valid     (i_riscv_em_valid),
        .i_riscv_em_opa       (i_riscv_em_opa),
        .i_riscv_em_opb       (i_riscv_em_opb),
        .i_riscv_em_aluop     (i_riscv_em_aluop),
        .i_riscv_em_regw      (i_riscv_em_regw),
        .i_riscv_em_memread   (i_riscv_em_memread),
        .i_riscv_em_memwrite  (i_riscv_em_memwrite),
        .i_riscv_em_resultsrc (i_riscv_em_resultsrc),
        .i_riscv_em_memext    (i_riscv_em_memext),
        .i_riscv_em_rdaddr    (i_riscv_em_rdaddr),
        .i_riscv_em_imm       (i_riscv_em_imm),
        .i_riscv_em_pc        (i_riscv_em_pc),
        .i_riscv_em_storedata (i_riscv_em_storedata),
        .o_riscv_em_ctrl      (ctrl_e),
        .o_riscv_em_data      (data_e)
    );

    riscv_em_ppreg #(.T(em_ctrl_t)) u_ppreg_ctrl (
        .i_riscv_em_clk   (i_riscv_em_clk),
        .i_riscv_em_rst   (i_riscv_em_rst),
        .i_riscv_em_stall (i_riscv_em_stall),
        .i_riscv_em_flush (i_riscv_em_flush),
        .i_riscv_em_d     (ctrl_e),
        .o_riscv_em_q     (ctrl_m)
    );

    riscv_em_ppreg #(.T(em_data_t)) u_ppreg_data (
        .i_riscv_em_clk   (i_riscv_em_clk),
        .i_riscv_em_rst   (i_riscv_em_rst),
        .i_riscv_em_stall (i_riscv_em_stall),
        .i_riscv_em_flush (i_riscv_em_flush),
        .i_riscv_em_d     (data_e),
        .o_riscv_em_q     (data_m)
    );

    riscv_em_mem_stage u_mem_stage (
        .i_riscv_em_ctrl       (ctrl_m),
        .i_riscv_em_data       (data_m),
        .i_riscv_em_dmem_rdata (i_riscv_em_dmem_rdata),
        .o_riscv_em_dmem_req   (o_riscv_em_dmem_req),
        .o_riscv_em_load_value (load_value)
    );

    riscv_em_wb_select u_wb_select (
        .i_riscv_em_ctrl       (ctrl_m),
        .i_riscv_em_data       (data_m),
        .i_riscv_em_load_value (load_value),
        .o_riscv_em_rd_data    (o_riscv_em_rd_data),
        .o_riscv_em_rd_addr    (o_riscv_em_rd_addr),
        .o_riscv_em_regw       (o_riscv_em_regw),
        .o_riscv_em_trap       (o_riscv_em_trap),
        .o_riscv_em_trap_cause (o_riscv_em_trap_cause)
    );

endmodule

//--- test/riscv_em_tb_checks.sv
`timescale 1ns/1ps
`include "riscv_em_macros.svh"

module riscv_em_tb_checks
    import riscv_em_ctrl_pkg::*, riscv_em_data_pkg::*;
(
    input  logic                          i_riscv_em_clk,
    input  logic                          i_riscv_em_rst,
    input  dmem_req_t                     i_dmem_req,
    input  logic [`RISCV_EM_XLEN-1:0]     i_rd_data,
    input  logic [`RISCV_EM_RADDR_W-1:0]  i_rd_addr,
    input  logic                          i_regw,
    input  logic                          i_trap,
    input  logic [`RISCV_EM_CAUSE_W-1:0]  i_trap_cause,
    input  logic                          i_valid_m,
    input  logic                          i_exp_valid,
    input  logic                          i_exp_regw,
    input  logic [`RISCV_EM_RADDR_W-1:0]  i_exp_rd_addr,
    input  logic                          i_exp_chk,
    input  logic [`RISCV_EM_XLEN-1:0]     i_exp_rd_data,
    input  logic                          i_exp_trap,
    input  logic [`RISCV_EM_CAUSE_W-1:0]  i_exp_cause,
    input  logic                          i_exp_we,
    input  logic [`RISCV_EM_XLEN/8-1:0]   i_exp_strb,
    input  logic [`RISCV_EM_XLEN-1:0]     i_exp_wdata,
    input  logic                          i_exp_mem,
    input  logic [`RISCV_EM_XLEN-1:0]     i_exp_addr
);

    int check_count = 0;
    int error_count = 0;

    // one byte of ones per set strobe bit
    function automatic logic [63:0] lane_mask(input logic [7:0] strb);
        logic [63:0] m;
        for (int i = 0; i < 8; i++)
            m[8*i +: 8] = {8{strb[i]}};
        return m;
    endfunction

    // sampled on the falling edge, half a cycle after the register updates
    a_valid: assert property (@(negedge i_riscv_em_clk) disable iff (i_riscv_em_rst)
        i_valid_m == i_exp_valid) check_count++;
    else
    begin
        error_count++;
        $error("mismatch at %0t: ctrl_m.valid got %h expected %h",
               $time, $sampled(i_valid_m), $sampled(i_exp_valid));
    end

    a_regw: assert property (@(negedge i_riscv_em_clk) disable iff (i_riscv_em_rst)
        i_regw == i_exp_regw) check_count++;
    else
    begin
        error_count++;
        $error("mismatch at %0t: o_riscv_em_regw got %h expected %h",
               $time, $sampled(i_regw), $sampled(i_exp_regw));
    end

    a_rd_addr: assert property (@(negedge i_riscv_em_clk) disable iff (i_riscv_em_rst)
        i_exp_regw |-> i_rd_addr == i_exp_rd_addr) check_count++;
    else
    begin
        error_count++;
        $error("mismatch at %0t: o_riscv_em_rd_addr got %h expected %h",
               $time, $sampled(i_rd_addr), $sampled(i_exp_rd_addr));
    end

    a_rd_data: assert property (@(negedge i_riscv_em_clk) disable iff (i_riscv_em_rst)
        i_exp_chk |-> i_rd_data == i_exp_rd_data) check_count++;
    else
    begin
        error_count++;
        $error("mismatch at %0t: o_riscv_em_rd_data got %h expected %h",
               $time, $sampled(i_rd_data), $sampled(i_exp_rd_data));
    end

    a_trap: assert property (@(negedge i_riscv_em_clk) disable iff (i_riscv_em_rst)
        i_trap == i_exp_trap) check_count++;
    else
    begin
        error_count++;
        $error("mismatch at %0t: o_riscv_em_trap got %h expected %h",
               $time, $sampled(i_trap), $sampled(i_exp_trap));
    end

    a_cause: assert property (@(negedge i_riscv_em_clk) disable iff (i_riscv_em_rst)
        i_exp_trap |-> i_trap_cause == i_exp_cause) check_count++;
    else
    begin
        error_count++;
        $error("mismatch at %0t: o_riscv_em_trap_cause got %h expected %h",
               $time, $sampled(i_trap_cause), $sampled(i_exp_cause));
    end

    a_we: assert property (@(negedge i_riscv_em_clk) disable iff (i_riscv_em_rst)
        i_dmem_req.we == i_exp_we) check_count++;
    else
    begin
        error_count++;
        $error("mismatch at %0t: dmem_req.we got %h expected %h",
               $time, $sampled(i_dmem_req.we), $sampled(i_exp_we));
    end

    a_strb: assert property (@(negedge i_riscv_em_clk) disable iff (i_riscv_em_rst)
        i_dmem_req.strb == i_exp_strb) check_count++;
    else
    begin
        error_count++;
        $error("mismatch at %0t: dmem_req.strb got %h expected %h",
               $time, $sampled(i_dmem_req.strb), $sampled(i_exp_strb));
    end

    // only the strobed lanes carry meaning
    a_wdata: assert property (@(negedge i_riscv_em_clk) disable iff (i_riscv_em_rst)
        i_exp_we |-> (i_dmem_req.wdata & lane_mask(i_exp_strb)) ==
                     (i_exp_wdata & lane_mask(i_exp_strb))) check_count++;
    else
    begin
        error_count++;
        $error("mismatch at %0t: dmem_req.wdata got %h expected %h",
               $time, $sampled(i_dmem_req.wdata), $sampled(i_exp_wdata));
    end

    a_addr: assert property (@(negedge i_riscv_em_clk) disable iff (i_riscv_em_rst)
        i_exp_mem |-> i_dmem_req.addr == i_exp_addr) check_count++;
    else
    begin
        error_count++;
        $error("mismatch at %0t: dmem_req.addr got %h expected %h",
               $time, $sampled(i_dmem_req.addr), $sampled(i_exp_addr));
    end

endmodule

//--- test/riscv_em_tb.sv
`timescale 1ns/1ps
`include "riscv_em_macros.svh"

module riscv_em_tb
    import riscv_em_ctrl_pkg::*, riscv_em_data_pkg::*;
;

    localparam logic [63:0] FILL_KEY = 64'h0123_4567_89ab_cdef;

    logic                         clk = 1'b0;
    logic                         rst;
    logic                         valid;
    logic                         regw;
    logic                         memread;
    logic                         memwrite;
    logic                         stall;
    logic                         flush;
    logic [`RISCV_EM_XLEN-1:0]    opa;
    logic [`RISCV_EM_XLEN-1:0]    opb;
    logic [`RISCV_EM_XLEN-1:0]    imm;
    logic [`RISCV_EM_XLEN-1:0]    pc;
    logic [`RISCV_EM_XLEN-1:0]    storedata;
    logic [`RISCV_EM_XLEN-1:0]    dmem_rdata;
    logic [`RISCV_EM_XLEN-1:0]    rd_data;
    aluop_e                       aluop;
    resultsrc_e                   resultsrc;
    memext_e                      memext;
    logic [`RISCV_EM_RADDR_W-1:0] rdaddr;
    logic [`RISCV_EM_RADDR_W-1:0] rd_addr;
    logic [`RISCV_EM_RADDR_W-1:0] exp_rd_addr;
    dmem_req_t                    dmem_req;
    logic                         regw_out;
    logic                         trap;
    logic [`RISCV_EM_CAUSE_W-1:0] trap_cause;
    logic [`RISCV_EM_CAUSE_W-1:0] exp_cause;
    logic                         exp_valid;
    logic                         exp_regw;
    logic                         exp_chk;
    logic                         exp_trap;
    logic                         exp_we;
    logic                         exp_mem;
    logic [`RISCV_EM_XLEN-1:0]    exp_rd_data;
    logic [`RISCV_EM_XLEN-1:0]    exp_wdata;
    logic [`RISCV_EM_XLEN-1:0]    exp_addr;
    logic [`RISCV_EM_XLEN/8-1:0]  exp_strb;
    integer                       seed = 32'hcbc1;
    int                           timeouts = 0;
    int                           mem_gen = 0;
    logic [63:0]                  mem [logic [63:0]];     // doubleword lines
    logic [7:0]                   ref_mem [logic [63:0]]; // bytes the tb expects

    riscv_em_top u_riscv_em_top (
        .i_riscv_em_clk        (clk),
        .i_riscv_em_rst        (rst),
        .i_riscv_em_valid      (valid),
        .i_riscv_em_opa        (opa),
        .i_riscv_em_opb        (opb),
        .i_riscv_em_aluop      (aluop),
        .i_riscv_em_regw       (regw),
        .i_riscv_em_memread    (memread),
        .i_riscv_em_memwrite   (memwrite),
        .i_riscv_em_resultsrc  (resultsrc),
        .i_riscv_em_memext     (memext),
        .i_riscv_em_rdaddr     (rdaddr),
        .i_riscv_em_imm        (imm),
        .i_riscv_em_pc         (pc),
        .i_riscv_em_storedata  (storedata),
        .i_riscv_em_stall      (stall),
        .i_riscv_em_flush      (flush),
        .i_riscv_em_dmem_rdata (dmem_rdata),
        .o_riscv_em_dmem_req   (dmem_req),
        .o_riscv_em_rd_data    (rd_data),
        .o_riscv_em_rd_addr    (rd_addr),
        .o_riscv_em_regw       (regw_out),
        .o_riscv_em_trap       (trap),
        .o_riscv_em_trap_cause (trap_cause)
    );

    bind riscv_em_top riscv_em_tb_checks u_checks (
        .i_riscv_em_clk (i_riscv_em_clk),
        .i_riscv_em_rst (i_riscv_em_rst),
        .i_dmem_req     (o_riscv_em_dmem_req),
        .i_rd_data      (o_riscv_em_rd_data),
        .i_rd_addr      (o_riscv_em_rd_addr),
        .i_regw         (o_riscv_em_regw),
        .i_trap         (o_riscv_em_trap),
        .i_trap_cause   (o_riscv_em_trap_cause),
        .i_valid_m      (ctrl_m.valid),
        .i_exp_valid    (riscv_em_tb.exp_valid),
        .i_exp_regw     (riscv_em_tb.exp_regw),
        .i_exp_rd_addr  (riscv_em_tb.exp_rd_addr),
        .i_exp_chk      (riscv_em_tb.exp_chk),
        .i_exp_rd_data  (riscv_em_tb.exp_rd_data),
        .i_exp_trap     (riscv_em_tb.exp_trap),
        .i_exp_cause    (riscv_em_tb.exp_cause),
        .i_exp_we       (riscv_em_tb.exp_we),
        .i_exp_strb     (riscv_em_tb.exp_strb),
        .i_exp_wdata    (riscv_em_tb.exp_wdata),
        .i_exp_mem      (riscv_em_tb.exp_mem),
        .i_exp_addr     (riscv_em_tb.exp_addr)
    );

    initial
    begin
        forever #5 clk = ~clk;
    end

    function automatic logic [63:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    // untouched lines read back a pattern of their own address
    function automatic logic [63:0] read_line(input logic [63:0] a);
        return mem.exists(a) ? mem[a] : (a ^ FILL_KEY);
    endfunction

    function automatic logic [7:0] ref_byte(input logic [63:0] a);
        logic [63:0] line;
        line = {a[63:3], 3'b000} ^ FILL_KEY;
        return ref_mem.exists(a) ? ref_mem[a] : line[8*a[2:0] +: 8];
    endfunction

    function automatic logic [63:0] expect_load(input logic [63:0] a, input memext_e ext);
        logic [63:0] v;
        int          n;
        v = '0;
        n = 1 << ext[1:0];
        for (int i = 0; i < n; i++)
            v[8*i +: 8] = ref_byte(a + i);
        if (!ext[2] && n < 8 && v[8*n-1])
            v = v | ({64{1'b1}} << (8*n)); // sign fill
        return v;
    endfunction

    // memory model, written on the clock edge that ends the store's cycle
    always @(posedge clk)
    begin : mem_write
        logic [63:0] line;
        if (dmem_req.we)
        begin
            line = read_line(dmem_req.addr);
            for (int i = 0; i < 8; i++)
                if (dmem_req.strb[i])
                    line[8*i +: 8] = dmem_req.wdata[8*i +: 8];
            mem[dmem_req.addr] = line;
            mem_gen <= mem_gen + 1;
        end
    end

    always @(dmem_req or mem_gen)
        dmem_rdata = read_line(dmem_req.addr);

    task automatic set_idle();
        valid = 1'b0;
        opa = '0;
        opb = '0;
        aluop = ALU_ADD;
        regw = 1'b0;
        memread = 1'b0;
        memwrite = 1'b0;
        resultsrc = RES_ALU;
        memext = MEXT_D;
        rdaddr = '0;
        imm = '0;
        pc = '0;
        storedata = '0;
    endtask

    task automatic clear_expect();
        exp_valid = 1'b0;
        exp_regw = 1'b0;
        exp_rd_addr = '0;
        exp_chk = 1'b0;
        exp_rd_data = '0;
        exp_trap = 1'b0;
        exp_cause = '0;
        exp_we = 1'b0;
        exp_strb = '0;
        exp_wdata = '0;
        exp_mem = 1'b0;
        exp_addr = '0;
    endtask

    task automatic do_alu(input aluop_e op);
        logic [63:0] a;
        logic [63:0] b;
        a = rand64();
        b = rand64();
        @(negedge clk);
        set_idle();
        clear_expect();
        valid = 1'b1;
        opa = a;
        opb = b;
        aluop = op;
        regw = 1'b1;
        rdaddr = 5'd1 + op;
        exp_valid = 1'b1;
        exp_regw = 1'b1;
        exp_rd_addr = 5'd1 + op;
        exp_chk = 1'b1;
        case (op)
            ALU_ADD: exp_rd_data = a + b;
            ALU_SUB: exp_rd_data = a - b;
            ALU_AND: exp_rd_data = a & b;
            ALU_OR:  exp_rd_data = a | b;
            default: exp_rd_data = a ^ b;
        endcase
    endtask

    // pc plus 4 and immediate write-back paths
    task automatic drive_wb_source(input resultsrc_e src);
        logic [63:0] p;
        logic [63:0] v;
        p = rand64();
        v = rand64();
        @(negedge clk);
        set_idle();
        clear_expect();
        valid = 1'b1;
        regw = 1'b1;
        resultsrc = src;
        pc = p;
        imm = v;
        rdaddr = 5'd12;
        exp_valid = 1'b1;
        exp_regw = 1'b1;
        exp_rd_addr = 5'd12;
        exp_chk = 1'b1;
        exp_rd_data = (src == RES_PC4) ? p + 64'd4 : v;
    endtask

    task automatic do_access(input logic store, input logic [63:0] addr,
                             input memext_e ext, input logic [63:0] data);
        int   n;
        logic mis;
        n = 1 << ext[1:0];
        mis = (addr % n) != 0;
        @(negedge clk);
        set_idle();
        clear_expect();
        valid = 1'b1;
        opa = {addr[63:8], 8'h00}; // base plus offset gives addr
        imm = {56'd0, addr[7:0]};
        memext = ext;
        storedata = data;
        rdaddr = 5'd9;
        exp_valid = 1'b1;
        exp_trap = mis;
        exp_mem = 1'b1;
        exp_addr = {addr[63:3], 3'b000};
        if (store)
        begin
            memwrite = 1'b1;
            exp_we = !mis;
            exp_strb = mis ? 8'h00 : (8'((1 << n) - 1) << addr[2:0]);
            exp_wdata = data << (8 * addr[2:0]);
            if (mis)
                exp_cause = `RISCV_EM_CAUSE_ST_MISALIGN;
            else
                for (int i = 0; i < n; i++)
                    ref_mem[addr + i] = data[8*i +: 8];
        end
        else
        begin
            memread = 1'b1;
            regw = 1'b1;
            resultsrc = RES_LOAD;
            exp_regw = !mis;
            exp_rd_addr = 5'd9;
            exp_chk = !mis;
            exp_rd_data = expect_load(addr, ext);
            if (mis)
                exp_cause = `RISCV_EM_CAUSE_LD_MISALIGN;
        end
    endtask

    task automatic wait_trap();
        int n;
        n = 0;
        @(posedge clk);
        #2;
        while (!trap && n < 4)
        begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!trap)
        begin
            timeouts++;
            $display("timeout at %0t: no trap raised for a misaligned access", $time);
        end
    endtask

    task automatic wait_reset_done();
        int n;
        n = 0;
        while ((regw_out || trap || dmem_req.we) && n < 8)
        begin
            @(posedge clk);
            #2;
            n++;
        end
        if (regw_out || trap || dmem_req.we)
        begin
            timeouts++;
            $display("timeout at %0t: control outputs still high after reset", $time);
        end
    endtask

    initial
    begin
        rst = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        dmem_rdata = '0;
        set_idle();
        clear_expect();
        repeat (5) @(negedge clk);
        rst = 1'b0;
        wait_reset_done();
        for (int k = 0; k < 10; k++)
            do_alu(aluop_e'(k % 5));
        drive_wb_source(RES_PC4);
        drive_wb_source(RES_IMM);
        do_access(1'b1, 64'h1003, MEXT_B, rand64());
        do_access(1'b1, 64'h100a, MEXT_H, rand64());
        do_access(1'b1, 64'h1014, MEXT_W, rand64());
        do_access(1'b1, 64'h1028, MEXT_D, rand64());
        do_access(1'b0, 64'h1003, MEXT_BU, '0);
        do_access(1'b0, 64'h100a, MEXT_HU, '0);
        do_access(1'b0, 64'h1014, MEXT_WU, '0);
        do_access(1'b0, 64'h1028, MEXT_D, '0);
        for (int k = 0; k < 8; k++)
            do_access(1'b0, 64'h2000 + 8 * k, memext_e'(k), '0);
        do_access(1'b0, 64'h1003, MEXT_B, '0);
        do_access(1'b0, 64'h100a, MEXT_H, '0);
        do_access(1'b0, 64'h1014, MEXT_W, '0);
        do_access(1'b0, 64'h1016, MEXT_W, '0);
        wait_trap();
        do_access(1'b0, 64'h1004, MEXT_D, '0);
        wait_trap();
        do_access(1'b1, 64'h1003, MEXT_H, rand64());
        wait_trap();
        do_access(1'b1, 64'h1016, MEXT_W, rand64());
        wait_trap();
        do_access(1'b0, 64'h1000, MEXT_D, '0); // bytes untouched by the traps
        do_access(1'b0, 64'h1010, MEXT_D, '0);
        do_alu(ALU_ADD);
        repeat (3)
        begin
            @(negedge clk);
            stall = 1'b1;
            opa = rand64(); // new operands must not leak through
        end
        @(negedge clk);
        flush = 1'b1;
        clear_expect();
        @(negedge clk);
        flush = 1'b0;
        stall = 1'b0;
        set_idle();
        repeat (2) @(negedge clk);
        $display("checks %0d, errors %0d, timeouts %0d",
                 u_riscv_em_top.u_checks.check_count,
                 u_riscv_em_top.u_checks.error_count, timeouts);
        if (u_riscv_em_top.u_checks.error_count == 0 && timeouts == 0 &&
            u_riscv_em_top.u_checks.check_count > 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- compile.f
+incdir+source
source/riscv_em_ctrl_pkg.sv
source/riscv_em_data_pkg.sv
source/riscv_em_ppreg.sv
source/riscv_em_exec_side.sv
source/riscv_em_mem_stage.sv
source/riscv_em_wb_select.sv
source/riscv_em_top.sv
test/riscv_em_tb_checks.sv
test/riscv_em_tb.sv
